/* include/bnn_weights.svh */
`ifndef BNN_WEIGHTS_SVH
`define BNN_WEIGHTS_SVH

// Hidden signs per feature row, feature 15 first
`define BNN_HIDDEN_WEIGHTS_VAL { \
  40'h3b9e4_c17a2, 40'h8d05f_62e9b, \
  40'hc4a71_0f3d6, 40'h5e28b_d94c1, \
  40'h0a6f3_7be58, 40'hf19c2_a4076, \
  40'h6d3b8_e51a9, 40'h92e07_4cb3f, \
  40'h47c5a_b1e20, 40'hb80d6_39f4c, \
  40'h1f6a9_c27d5, 40'he35b0_8a4f1, \
  40'h7a914_d6c0e, 40'h2cd7e_f0839, \
  40'hd4086_5b1fa, 40'h9b7f1_2e6c4 }

// Output weight rows, class 9 first
`define BNN_OUTPUT_WEIGHTS_VAL { \
  40'h6b2d9_e1047, 40'ha57c0_3f8d2, \
  40'h1e94b_7c26a, 40'hd0b63_58ef1, \
  40'h7f215_a9c3e, 40'h3ac8e_06b5d, \
  40'hc649f_d2187, 40'h58e1a_b37c0, \
  40'he20d7_4a9f6, 40'h94b3c_e5d28 }

`endif

/* logic/bnn_pkg.sv */
package bnn_pkg;

`include "bnn_weights.svh"

  // Input sample
  localparam int NUM_FEATURES = 16;
  localparam int FEATURE_W    = 4;
  localparam int DATA_W       = NUM_FEATURES * FEATURE_W; // Feature i at bits 4i+3:4i

  // Network shape
  localparam int NUM_HIDDEN  = 40;
  localparam int NUM_CLASSES = 10;

  // Sum of 16 features of up to 15 either way, plus sign
  localparam int ACC_W      = FEATURE_W + $clog2(NUM_FEATURES) + 1;
  localparam int SCORE_W    = $clog2(NUM_HIDDEN + 1); // 0 to 40
  localparam int CLASS_W    = $clog2(NUM_CLASSES);
  localparam int FEAT_IDX_W = $clog2(NUM_FEATURES);
  localparam int HID_IDX_W  = $clog2(NUM_HIDDEN);

  // Row f at bits 40f upward, bit n set means add feature f to neuron n
  localparam logic [NUM_FEATURES*NUM_HIDDEN-1:0] HIDDEN_WEIGHTS =
    `BNN_HIDDEN_WEIGHTS_VAL;

  // Row c at bits 40c upward, bit n is the weight of hidden neuron n
  localparam logic [NUM_CLASSES*NUM_HIDDEN-1:0] OUTPUT_WEIGHTS =
    `BNN_OUTPUT_WEIGHTS_VAL;

endpackage

/* logic/hidden_layer.sv */
module hidden_layer (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                start,
  input  logic [bnn_pkg::DATA_W-1:0]          data,
  output logic [bnn_pkg::NUM_HIDDEN-1:0]      hidden_bits,
  output logic                                hidden_valid,
  output logic                                busy
);

  import bnn_pkg::*;

  logic [DATA_W-1:0]       sample;
  logic [FEAT_IDX_W-1:0]   feat_idx;
  logic [FEATURE_W-1:0]    feature;
  logic signed [ACC_W-1:0] feat_ext;
  logic [NUM_HIDDEN-1:0]   row;
  logic                    last_feat;
  logic signed [ACC_W-1:0] acc      [NUM_HIDDEN];
  logic signed [ACC_W-1:0] acc_next [NUM_HIDDEN];
  logic [NUM_HIDDEN-1:0]   signs;

  assign feature   = sample[feat_idx*FEATURE_W +: FEATURE_W];
  assign feat_ext  = ACC_W'(feature);                              // Always positive
  assign row       = HIDDEN_WEIGHTS[feat_idx*NUM_HIDDEN +: NUM_HIDDEN];
  assign last_feat = (feat_idx == FEAT_IDX_W'(NUM_FEATURES - 1));

  // One add or subtract per neuron for the current feature
  always_comb begin
    for (int n = 0; n < NUM_HIDDEN; n++) begin
      if (row[n]) begin
        acc_next[n] = acc[n] + feat_ext;
      end else begin
        acc_next[n] = acc[n] - feat_ext;
      end
      signs[n] = ~acc_next[n][ACC_W-1]; // Sum >= 0
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy         <= 1'b0;
      feat_idx     <= '0;
      hidden_valid <= 1'b0;
    end else begin
      hidden_valid <= busy & last_feat;
      if (start) begin
        busy     <= 1'b1;
        feat_idx <= '0;
      end else if (busy) begin
        feat_idx <= feat_idx + 1'b1;
        if (last_feat) begin
          busy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      sample <= data;
      for (int n = 0; n < NUM_HIDDEN; n++) begin
        acc[n] <= '0;
      end
    end else if (busy) begin
      for (int n = 0; n < NUM_HIDDEN; n++) begin
        acc[n] <= acc_next[n];
      end
      if (last_feat) begin
        hidden_bits <= signs; // Full sums after feature 15
      end
    end
  end

endmodule

/* logic/output_layer.sv */
module output_layer (
  input  logic                                            clk,
  input  logic                                            rst,
  input  logic                                            hidden_valid,
  input  logic [bnn_pkg::NUM_HIDDEN-1:0]                  hidden_bits,
  output logic [bnn_pkg::NUM_CLASSES*bnn_pkg::SCORE_W-1:0] scores,
  output logic                                            scores_valid,
  output logic                                            busy
);

  import bnn_pkg::*;

  logic [NUM_HIDDEN-1:0]  bits_q;
  logic [HID_IDX_W-1:0]   bit_idx;
  logic                   hid_bit;
  logic                   last_bit;
  logic [NUM_CLASSES-1:0] match;
  logic [SCORE_W-1:0]     count [NUM_CLASSES];

  assign hid_bit  = bits_q[bit_idx];
  assign last_bit = (bit_idx == HID_IDX_W'(NUM_HIDDEN - 1));

  // XNOR of the current hidden bit against each class row
  always_comb begin
    for (int c = 0; c < NUM_CLASSES; c++) begin
      match[c] = ~(hid_bit ^ OUTPUT_WEIGHTS[c*NUM_HIDDEN + int'(bit_idx)]);
    end
  end

  genvar gc;
  generate
    for (gc = 0; gc < NUM_CLASSES; gc++) begin : g_pack
      assign scores[gc*SCORE_W +: SCORE_W] = count[gc];
    end
  endgenerate

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy         <= 1'b0;
      bit_idx      <= '0;
      scores_valid <= 1'b0;
    end else begin
      scores_valid <= busy & last_bit;
      if (hidden_valid) begin
        busy    <= 1'b1;
        bit_idx <= '0;
      end else if (busy) begin
        bit_idx <= bit_idx + 1'b1;
        if (last_bit) begin
          busy <= 1'b0; // Bit 39 done
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hidden_valid) begin
      bits_q <= hidden_bits;
      for (int c = 0; c < NUM_CLASSES; c++) begin
        count[c] <= '0;
      end
    end else if (busy) begin
      for (int c = 0; c < NUM_CLASSES; c++) begin
        count[c] <= count[c] + SCORE_W'(match[c]);
      end
    end
  end

endmodule

/* logic/class_argmax.sv */
module class_argmax (
  input  logic                                             clk,
  input  logic                                             rst,
  input  logic [bnn_pkg::NUM_CLASSES*bnn_pkg::SCORE_W-1:0] scores,
  input  logic                                             scores_valid,
  output logic [bnn_pkg::CLASS_W-1:0]                      class_id,
  output logic                                             class_valid
);

  import bnn_pkg::*;

  logic [SCORE_W-1:0] score [NUM_CLASSES];
  logic [SCORE_W-1:0] best_score;
  logic [CLASS_W-1:0] best_idx;

  genvar gc;
  generate
    for (gc = 0; gc < NUM_CLASSES; gc++) begin : g_unpack
      assign score[gc] = scores[gc*SCORE_W +: SCORE_W];
    end
  endgenerate

  // Strict compare keeps the lowest index on a tie
  always_comb begin
    best_score = score[0];
    best_idx   = '0;
    for (int c = 1; c < NUM_CLASSES; c++) begin
      if (score[c] > best_score) begin
        best_score = score[c];
        best_idx   = CLASS_W'(c);
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      class_id    <= '0;
      class_valid <= 1'b0;
    end else begin
      class_valid <= scores_valid;
      if (scores_valid) begin
        class_id <= best_idx; // Held until next result
      end
    end
  end

endmodule

/* logic/bnn_classifier.sv */
module bnn_classifier (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          start,
  input  logic [bnn_pkg::DATA_W-1:0]    data,
  output logic                          busy,
  output logic                          class_valid,
  output logic [bnn_pkg::CLASS_W-1:0]   class_id
);

  import bnn_pkg::*;

  logic                             start_ok;
  logic                             h_busy;
  logic                             o_busy;
  logic [NUM_HIDDEN-1:0]            hidden_bits;
  logic                             hidden_valid;
  logic [NUM_CLASSES*SCORE_W-1:0]   scores;
  logic                             scores_valid;

  assign start_ok = start & ~busy; // Starts during a run are dropped

  // Stage pulses cover the cycle between one stage finishing and the next
  assign busy = h_busy | hidden_valid | o_busy | scores_valid;

  hidden_layer u_hidden (
    .clk          (clk),
    .rst          (rst),
    .start        (start_ok),
    .data         (data),
    .hidden_bits  (hidden_bits),
    .hidden_valid (hidden_valid),
    .busy         (h_busy)
  );

  output_layer u_output (
    .clk          (clk),
    .rst          (rst),
    .hidden_valid (hidden_valid),
    .hidden_bits  (hidden_bits),
    .scores       (scores),
    .scores_valid (scores_valid),
    .busy         (o_busy)
  );

  class_argmax u_argmax (
    .clk          (clk),
    .rst          (rst),
    .scores       (scores),
    .scores_valid (scores_valid),
    .class_id     (class_id),
    .class_valid  (class_valid)
  );

endmodule

/* testbench/bnn_classifier_sva.sv */
module bnn_classifier_sva (
  input logic clk,
  input logic rst,
  input logic start,
  input logic busy,
  input logic class_valid
);

  timeunit 1ns;
  timeprecision 100ps;

  logic run_pending;

  // Set by an accepted start, cleared by the result
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      run_pending <= 1'b0;
    end else if (start && !busy) begin
      run_pending <= 1'b1;
    end else if (class_valid) begin
      run_pending <= 1'b0;
    end
  end

  valid_one_cycle: assert property (
    @(posedge clk) disable iff (rst) class_valid |=> !class_valid
  ) else $error("class_valid high for more than one cycle");

  valid_busy_low: assert property (
    @(posedge clk) disable iff (rst) class_valid |-> !busy
  ) else $error("busy still high with class_valid");

  valid_after_start: assert property (
    @(posedge clk) disable iff (rst) class_valid |-> run_pending
  ) else $error("class_valid without an accepted start");

endmodule

bind bnn_classifier bnn_classifier_sva u_sva (
  .clk         (clk),
  .rst         (rst),
  .start       (start),
  .busy        (busy),
  .class_valid (class_valid)
);

/* testbench/bnn_classifier_tb.sv */
module bnn_classifier_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import bnn_pkg::*;

  localparam int CLK_PERIOD      = 4;
  localparam int RESET_CYCLES    = 5;
  localparam int NUM_TESTS       = 12;
  localparam int LATENCY         = 58; // Edges from start sample to class_valid
  localparam int BUSY_START_EDGE = 4;  // Start during the hidden layer
  localparam int BUSY_START_STEP = 12; // Then the layer gap, then the output layer
  localparam int WATCHDOG_CYCLES = NUM_TESTS * 70 + 20;

  logic               clk;
  logic               rst;
  logic               start;
  logic [DATA_W-1:0]  data;
  logic               busy;
  logic               class_valid;
  logic [CLASS_W-1:0] class_id;

  // Stimulus table
  logic [DATA_W-1:0]  tbl_data  [NUM_TESTS];
  int                 tbl_delay [NUM_TESTS]; // Idle cycles before start
  logic [CLASS_W-1:0] tbl_class [NUM_TESTS];

  integer seed;
  int     error_count;
  int     tests_failed;

  bnn_classifier UUT (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .data        (data),
    .busy        (busy),
    .class_valid (class_valid),
    .class_id    (class_id)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Reference network built straight from the weight rows
  function automatic int model_class(input logic [DATA_W-1:0] sample);
    int sum;
    int feat;
    int score;
    int best_score;
    int best_class;
    logic [NUM_HIDDEN-1:0] hidden;
    for (int n = 0; n < NUM_HIDDEN; n++) begin
      sum = 0;
      for (int f = 0; f < NUM_FEATURES; f++) begin
        feat = int'(sample[f*FEATURE_W +: FEATURE_W]);
        if (HIDDEN_WEIGHTS[f*NUM_HIDDEN + n]) begin
          sum = sum + feat;
        end else begin
          sum = sum - feat;
        end
      end
      hidden[n] = (sum >= 0);
    end
    best_score = -1;
    best_class = 0;
    for (int c = 0; c < NUM_CLASSES; c++) begin
      score = 0;
      for (int n = 0; n < NUM_HIDDEN; n++) begin
        if (hidden[n] == OUTPUT_WEIGHTS[c*NUM_HIDDEN + n]) begin
          score = score + 1;
        end
      end
      if (score > best_score) begin // Lowest index wins a tie
        best_score = score;
        best_class = c;
      end
    end
    return best_class;
  endfunction

  task automatic fill_table();
    logic [31:0] rnd_hi;
    logic [31:0] rnd_lo;
    tbl_data[0] = '0;
    tbl_data[1] = '1;
    tbl_data[2] = {8{8'hf0}};              // Features alternate 0 and 15
    tbl_data[3] = 64'h0000_0000_0000_000f; // Feature 0 only
    tbl_data[4] = 64'h0000_0000_f000_0000; // Feature 7 only
    tbl_data[5] = 64'hf000_0000_0000_0000; // Feature 15 only
    for (int i = 6; i < NUM_TESTS; i++) begin
      rnd_hi = $random(seed);
      rnd_lo = $random(seed);
      tbl_data[i] = {rnd_hi, rnd_lo};
    end
    for (int i = 0; i < NUM_TESTS; i++) begin
      tbl_delay[i] = i % 3;
      tbl_class[i] = CLASS_W'(model_class(tbl_data[i]));
    end
  endtask

  task automatic compare_bit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("ERROR %s expected 0x%h got 0x%h", name, expected, actual);
      error_count++;
    end
  endtask

  task automatic check_idle(input logic in_reset);
    compare_bit("busy", 1'b0, busy);
    compare_bit("class_valid", 1'b0, class_valid);
    if (in_reset && class_id !== '0) begin
      $display("ERROR class_id expected 0x0 got 0x%h", class_id);
      error_count++;
    end
  endtask

  task automatic run_test(input int idx);
    logic [DATA_W-1:0] sample;
    int                edges;
    int                busy_edge;
    logic              seen;
    logic              busy_dropped;
    logic              busy_start;
    sample       = tbl_data[idx];
    busy_start   = (idx % 4 == 3); // These runs also get a start while busy
    busy_edge    = BUSY_START_EDGE + (idx / 4) * BUSY_START_STEP;
    edges        = 0;
    seen         = 1'b0;
    busy_dropped = 1'b0;
    repeat (tbl_delay[idx]) begin
      @(posedge clk);
      @(negedge clk);
      check_idle(1'b0);
    end
    @(posedge clk);
    start <= 1'b1;
    data  <= sample;
    @(posedge clk); // Edge 0
    start <= 1'b0;
    while (!seen) begin
      @(negedge clk);
      if (class_valid === 1'b1) begin
        seen = 1'b1;
        if (edges != LATENCY) begin
          $display("class_valid rose %0d edges after start instead of %0d", edges, LATENCY);
          error_count++;
        end
        compare_bit("busy", 1'b0, busy);
        if (class_id !== tbl_class[idx]) begin
          $display("ERROR class_id expected 0x%h got 0x%h", tbl_class[idx], class_id);
          error_count++;
        end
      end else begin
        if (busy !== 1'b1 && !busy_dropped) begin
          busy_dropped = 1'b1;
          $display("ERROR busy expected 0x1 got 0x%h at edge %0d", busy, edges);
          error_count++;
        end
        @(posedge clk);
        edges++;
        if (busy_start && edges == busy_edge) begin
          start <= 1'b1;
          data  <= ~sample; // Must be ignored
        end else begin
          start <= 1'b0;
        end
      end
    end
    @(posedge clk);
    @(negedge clk);
    check_idle(1'b0); // Pulse over, no second run
  endtask

  task automatic report_test(input string label, input int errors_before);
    if (error_count == errors_before) begin
      $display("%s: ok", label);
    end else begin
      $display("%s: FAILED with %0d errors", label, error_count - errors_before);
      tests_failed++;
    end
  endtask

  initial begin
    int errors_before;
    clk          = 1'b0;
    rst          = 1'b1;
    start        = 1'b0;
    data         = '0;
    error_count  = 0;
    tests_failed = 0;
    seed         = 32'h47a8_3ea0;
    fill_table();

    errors_before = error_count;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_idle(1'b1);
    end
    @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_idle(1'b1);
    report_test("reset", errors_before);

    for (int i = 0; i < NUM_TESTS; i++) begin
      errors_before = error_count;
      run_test(i);
      report_test($sformatf("test %0d data 0x%h class %0d", i, tbl_data[i], tbl_class[i]),
                  errors_before);
    end

    $display("%0d tests, %0d passed, %0d failed, %0d errors", NUM_TESTS + 1,
             NUM_TESTS + 1 - tests_failed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    $display("Timeout after %0d clock cycles, the run did not complete", WATCHDOG_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

/* filelist.f */
+incdir+include
logic/bnn_pkg.sv
logic/hidden_layer.sv
logic/output_layer.sv
logic/class_argmax.sv
logic/bnn_classifier.sv
testbench/bnn_classifier_sva.sv
testbench/bnn_classifier_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the BNN classifier testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_MSG="FAIL: see errors above"

verilator --binary --timing --assert \
  --timescale 1ns/100ps \
  --top-module bnn_classifier_tb \
  -f filelist.f \
  -Mdir obj_dir -o bnn_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/bnn_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "$FAIL_MSG" "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0
